// File: common/DaqCtrlPkg.sv
package DaqCtrlPkg;

	//////////////////////
	// Chain size and counter widths
	//////////////////////
	localparam int NumChips = 4;                 // ASICs in the chain
	localparam int ChanBits = $clog2(NumChips);  // Channel index width
	localparam int TrigWidth = 24;               // Accepted trigger counter

	localparam int ChanDepth = 16;               // Capture FIFO depth per ASIC
	localparam int PtrWidth = $clog2(ChanDepth);
	localparam int CountWidth = PtrWidth + 1;    // Holds 0..ChanDepth
	localparam logic [CountWidth-1:0] FullCount = CountWidth'(ChanDepth);

	//////////////////////
	// Sequencer phase lengths, in Clk cycles
	//////////////////////
	localparam logic [15:0] TimePowerReset = 16'd8;    // Wake up the LVDS receivers
	localparam logic [15:0] TimeResetStart = 16'd40;   // Internal chip management
	localparam logic [15:0] TimeStartReadout = 16'd16; // StartReadout pulse width

	// Acquisition cycle, order matters for the power-pulsing ranges
	typedef enum logic [3:0] {
		IDLE           = 4'd0,
		CHIP_RESET     = 4'd1,
		POWER_ON       = 4'd2,
		RELEASE        = 4'd3,
		WAIT_START     = 4'd4,
		ACQUIRE        = 4'd5,
		WAIT_READ      = 4'd6,
		START_READOUT  = 4'd7,
		WAIT_READ_DONE = 4'd8,
		ONCE_END       = 4'd9,
		SESSION_END    = 4'd10,
		ALL_DONE       = 4'd11
	} SeqState;

endpackage

// File: common/DaqDataPkg.sv
package DaqDataPkg;

	// One word from an ASIC, Valid is a single-cycle strobe
	typedef struct packed {
		logic [15:0] Data;
		logic        Valid;
	} ChipWord;

	// Merged stream word towards the host
	typedef struct packed {
		logic [15:0] Data;
		logic        Valid;
	} OutWord;

	// Sequencer to merger
	typedef struct packed {
		logic                             BurstStart; // Drain the channels now
		logic                             SessionEnd; // Write the trailer now
		logic [DaqCtrlPkg::TrigWidth-1:0] TrigCount;
	} CtrlBus;

	//////////////////////
	// Stream code words
	//////////////////////
	localparam logic [7:0] MarkerTag = 8'hBB;  // Low byte carries the channel index
	localparam logic [7:0] TrigTag = 8'hAA;
	localparam logic [7:0] CountTag = 8'hCC;
	localparam logic [15:0] TailHead = 16'hFF45;
	localparam logic [15:0] TailEnd = 16'h45FF;

endpackage

// File: sequencer/AcqSequencer.sv
`timescale 1ns/1ps

module AcqSequencer (
	input  logic                Clk,
	input  logic                reset_n,
	input  logic                ModuleStart,      // Level from the host
	input  logic                AcqStart,         // External trigger
	input  logic                ChipSatB,         // Chip full, active low
	input  logic                EndReadout,
	input  logic [15:0]         AcquisitionTime,
	input  logic [15:0]         EndHoldTime,
	input  logic                DataTransmitDone,
	input  logic                BurstDone,
	input  logic                TrailerDone,
	output logic                RESET_B,
	output logic                START_ACQ,
	output logic                StartReadout,
	output logic                PWR_ON_A,
	output logic                PWR_ON_D,
	output logic                PWR_ON_DAC,
	output logic                OnceEnd,
	output logic                AllDone,
	output logic                ReadWindow,       // Gates the capture channels
	output DaqDataPkg::CtrlBus  Ctrl
);

	//////////////////////
	// Synchronizers and edges
	//////////////////////
	// Bits 0 and 1 form the synchronizer, bit 2 keeps the previous value
	logic [2:0] AcqSync;
	logic [2:0] SatSync;
	logic [2:0] EndSync;

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			AcqSync <= '0;
			SatSync <= '1;  // Not full
			EndSync <= '0;
		end else begin
			AcqSync <= {AcqSync[1:0], AcqStart};
			SatSync <= {SatSync[1:0], ChipSatB};
			EndSync <= {EndSync[1:0], EndReadout};
		end
	end

	logic AcqRise;
	logic SatFall;
	logic SatRise;
	logic EndFall;

	assign AcqRise = AcqSync[1] & ~AcqSync[2];
	assign SatFall = ~SatSync[1] & SatSync[2];  // A chip is full
	assign SatRise = SatSync[1] & ~SatSync[2];  // Readout may start
	assign EndFall = ~EndSync[1] & EndSync[2];

	//////////////////////
	// Acquisition FSM
	//////////////////////
	DaqCtrlPkg::SeqState State;
	logic [15:0] DelayCount;  // Shared by every timed phase
	logic [DaqCtrlPkg::TrigWidth-1:0] TrigCount;
	logic BurstStrobe;
	logic SessionStrobe;
	logic BurstSeen;

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			State <= DaqCtrlPkg::IDLE;
			DelayCount <= '0;
			TrigCount <= '0;
			RESET_B <= 1'b1;
			START_ACQ <= 1'b0;
			StartReadout <= 1'b0;
			ReadWindow <= 1'b0;
			OnceEnd <= 1'b0;
			AllDone <= 1'b0;
			BurstStrobe <= 1'b0;
			SessionStrobe <= 1'b0;
			BurstSeen <= 1'b0;
		end else begin
			BurstStrobe <= 1'b0;
			SessionStrobe <= 1'b0;
			if (EndFall)
				ReadWindow <= 1'b0;  // Window closes with EndReadout
			case (State)
				DaqCtrlPkg::IDLE: begin
					if (ModuleStart) begin
						RESET_B <= 1'b0;
						TrigCount <= '0;  // New session
						State <= DaqCtrlPkg::CHIP_RESET;
					end
				end
				DaqCtrlPkg::CHIP_RESET: State <= DaqCtrlPkg::POWER_ON;
				DaqCtrlPkg::POWER_ON: begin
					if (DelayCount < DaqCtrlPkg::TimePowerReset - 16'd1) begin
						DelayCount <= DelayCount + 16'd1;
					end else begin
						DelayCount <= '0;
						RESET_B <= 1'b1;
						State <= DaqCtrlPkg::RELEASE;
					end
				end
				DaqCtrlPkg::RELEASE: begin
					if (DelayCount < DaqCtrlPkg::TimeResetStart - 16'd1) begin
						DelayCount <= DelayCount + 16'd1;
					end else begin
						DelayCount <= '0;
						State <= DaqCtrlPkg::WAIT_START;
					end
				end
				DaqCtrlPkg::WAIT_START: begin
					if (!ModuleStart) begin
						SessionStrobe <= 1'b1;
						State <= DaqCtrlPkg::SESSION_END;
					end else if (AcqRise) begin
						TrigCount <= TrigCount + 1'b1;
						START_ACQ <= 1'b1;
						State <= DaqCtrlPkg::ACQUIRE;
					end
				end
				DaqCtrlPkg::ACQUIRE: begin
					// Timeout or saturation, whichever first
					if (SatFall || DelayCount + 16'd1 >= AcquisitionTime) begin
						DelayCount <= '0;
						START_ACQ <= 1'b0;
						State <= DaqCtrlPkg::WAIT_READ;
					end else begin
						DelayCount <= DelayCount + 16'd1;
					end
				end
				DaqCtrlPkg::WAIT_READ: begin
					if (SatRise) begin
						StartReadout <= 1'b1;
						ReadWindow <= 1'b1;
						State <= DaqCtrlPkg::START_READOUT;
					end
				end
				DaqCtrlPkg::START_READOUT: begin
					if (DelayCount < DaqCtrlPkg::TimeStartReadout - 16'd1) begin
						DelayCount <= DelayCount + 16'd1;
					end else begin
						DelayCount <= '0;
						StartReadout <= 1'b0;
						State <= DaqCtrlPkg::WAIT_READ_DONE;
					end
				end
				DaqCtrlPkg::WAIT_READ_DONE: begin
					// EndReadout may already have fallen during the pulse
					if (EndFall || !ReadWindow) begin
						OnceEnd <= 1'b1;
						BurstStrobe <= 1'b1;
						BurstSeen <= 1'b0;
						State <= DaqCtrlPkg::ONCE_END;
					end
				end
				DaqCtrlPkg::ONCE_END: begin
					if (BurstDone)
						BurstSeen <= 1'b1;
					if (DelayCount < EndHoldTime) begin
						DelayCount <= DelayCount + 16'd1;
					end else if (BurstSeen || BurstDone) begin
						DelayCount <= '0;
						OnceEnd <= 1'b0;
						State <= DaqCtrlPkg::WAIT_START;
					end
				end
				DaqCtrlPkg::SESSION_END: begin
					if (TrailerDone) begin
						AllDone <= 1'b1;
						State <= DaqCtrlPkg::ALL_DONE;
					end
				end
				DaqCtrlPkg::ALL_DONE: begin
					if (DataTransmitDone) begin
						AllDone <= 1'b0;
						State <= DaqCtrlPkg::IDLE;
					end
				end
				default: State <= DaqCtrlPkg::IDLE;
			endcase
		end
	end

	assign Ctrl = '{BurstStart: BurstStrobe, SessionEnd: SessionStrobe, TrigCount: TrigCount};

	//////////////////////
	// Power pulsing
	//////////////////////
	always_comb begin
		PWR_ON_A = (State >= DaqCtrlPkg::CHIP_RESET) && (State <= DaqCtrlPkg::ONCE_END);
		PWR_ON_DAC = PWR_ON_A;
		PWR_ON_D = (State >= DaqCtrlPkg::POWER_ON) && (State <= DaqCtrlPkg::ONCE_END);
	end

	StartAcqOnlyInAcquire: assert property (@(posedge Clk) disable iff (!reset_n)
		START_ACQ |-> State == DaqCtrlPkg::ACQUIRE);

	BurstAndSessionApart: assert property (@(posedge Clk) disable iff (!reset_n)
		Ctrl.BurstStart |-> !Ctrl.SessionEnd);

endmodule

// File: logic/ChipChannel.sv
`timescale 1ns/1ps

module ChipChannel (
	input  logic                                Clk,
	input  logic                                reset_n,
	input  DaqDataPkg::ChipWord                 ChipIn,
	input  logic                                ReadWindow,
	input  logic                                Pop,
	output logic [15:0]                         Head,   // Oldest word
	output logic [DaqCtrlPkg::CountWidth-1:0]   Count
);

	logic [15:0] Mem [DaqCtrlPkg::ChanDepth];
	logic [DaqCtrlPkg::PtrWidth-1:0] WrPtr;
	logic [DaqCtrlPkg::PtrWidth-1:0] RdPtr;
	logic Full;
	logic Push;

	assign Full = (Count == DaqCtrlPkg::FullCount);
	assign Push = ChipIn.Valid && ReadWindow && !Full;  // Words outside the window are lost
	assign Head = Mem[RdPtr];

	always_ff @(posedge Clk) begin
		if (Push)
			Mem[WrPtr] <= ChipIn.Data;
	end

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			WrPtr <= '0;
			RdPtr <= '0;
			Count <= '0;
		end else begin
			if (Push)
				WrPtr <= WrPtr + 1'b1;
			if (Pop)
				RdPtr <= RdPtr + 1'b1;
			case ({Push, Pop})
				2'b10: Count <= Count + 1'b1;
				2'b01: Count <= Count - 1'b1;
				default: Count <= Count;  // Idle or push with pop
			endcase
		end
	end

	NoPopWhenEmpty: assert property (@(posedge Clk) disable iff (!reset_n)
		Pop |-> Count != '0);

	NoPushWhenFull: assert property (@(posedge Clk) disable iff (!reset_n)
		(ChipIn.Valid && ReadWindow) |-> !Full);

endmodule

// File: logic/EventMerger.sv
`timescale 1ns/1ps

module EventMerger (
	input  logic                              Clk,
	input  logic                              reset_n,
	input  DaqDataPkg::CtrlBus                Ctrl,
	input  logic [15:0]                       Heads [DaqCtrlPkg::NumChips],
	input  logic [DaqCtrlPkg::CountWidth-1:0] Counts [DaqCtrlPkg::NumChips],
	output logic [DaqCtrlPkg::NumChips-1:0]   Pop,
	output DaqDataPkg::OutWord                Out,
	output logic                              BurstDone,
	output logic                              TrailerDone
);

	typedef enum logic [2:0] {PhIdle, PhMark, PhData, PhTrig1, PhTrig2, PhTail} MergePhase;

	MergePhase Phase;
	logic [DaqCtrlPkg::ChanBits-1:0] Chan;     // Channel being drained
	logic [1:0] TailIdx;
	logic [DaqCtrlPkg::CountWidth-1:0] Latched [DaqCtrlPkg::NumChips];

	// Lowest set bit, MSB of the result flags a hit
	function automatic logic [DaqCtrlPkg::ChanBits:0] lowestSet(
		input logic [DaqCtrlPkg::NumChips-1:0] Mask);
		logic [DaqCtrlPkg::ChanBits:0] Res;
		Res = '0;
		for (int i = DaqCtrlPkg::NumChips - 1; i >= 0; i--) begin
			if (Mask[i])
				Res = {1'b1, DaqCtrlPkg::ChanBits'(i)};
		end
		return Res;
	endfunction

	logic [DaqCtrlPkg::NumChips-1:0] StartMask;
	logic [DaqCtrlPkg::NumChips-1:0] NextMask;
	logic [DaqCtrlPkg::ChanBits:0] StartSel;
	logic [DaqCtrlPkg::ChanBits:0] NextSel;

	always_comb begin
		for (int i = 0; i < DaqCtrlPkg::NumChips; i++) begin
			StartMask[i] = (Counts[i] != '0);
			NextMask[i] = (Latched[i] != '0) && (i != int'(Chan));  // Channels still to drain
		end
		StartSel = lowestSet(StartMask);
		NextSel = lowestSet(NextMask);
	end

	//////////////////////
	// Sequencing
	//////////////////////
	always_ff @(posedge Clk) begin
		if (Phase == PhIdle && Ctrl.BurstStart)
			Latched <= Counts;
		else if (Phase == PhData)
			Latched[Chan] <= Latched[Chan] - 1'b1;
	end

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			Phase <= PhIdle;
			Chan <= '0;
			TailIdx <= '0;
			BurstDone <= 1'b0;
			TrailerDone <= 1'b0;
		end else begin
			BurstDone <= 1'b0;
			TrailerDone <= 1'b0;
			case (Phase)
				PhIdle: begin
					if (Ctrl.BurstStart) begin
						if (StartSel[DaqCtrlPkg::ChanBits]) begin
							Chan <= StartSel[DaqCtrlPkg::ChanBits-1:0];
							Phase <= PhMark;
						end else begin
							BurstDone <= 1'b1;  // Empty burst
						end
					end else if (Ctrl.SessionEnd) begin
						TailIdx <= '0;
						Phase <= PhTail;
					end
				end
				PhMark: Phase <= PhData;
				PhData: begin
					if (Latched[Chan] == DaqCtrlPkg::CountWidth'(1)) begin
						if (NextSel[DaqCtrlPkg::ChanBits]) begin
							Chan <= NextSel[DaqCtrlPkg::ChanBits-1:0];
							Phase <= PhMark;
						end else begin
							Phase <= PhTrig1;
						end
					end
				end
				PhTrig1: Phase <= PhTrig2;
				PhTrig2: begin
					BurstDone <= 1'b1;
					Phase <= PhIdle;
				end
				PhTail: begin
					TailIdx <= TailIdx + 1'b1;
					if (TailIdx == 2'd3) begin
						TrailerDone <= 1'b1;
						Phase <= PhIdle;
					end
				end
				default: Phase <= PhIdle;
			endcase
		end
	end

	//////////////////////
	// Output word
	//////////////////////
	always_comb begin
		Pop = '0;
		Out.Valid = (Phase != PhIdle);
		Out.Data = '0;
		case (Phase)
			PhMark: Out.Data = {DaqDataPkg::MarkerTag, 8'(Chan)};
			PhData: begin
				Out.Data = Heads[Chan];
				Pop[Chan] = 1'b1;
			end
			PhTrig1: Out.Data = {DaqDataPkg::TrigTag, Ctrl.TrigCount[23:16]};
			PhTrig2: Out.Data = Ctrl.TrigCount[15:0];
			PhTail: begin
				case (TailIdx)
					2'd0: Out.Data = DaqDataPkg::TailHead;
					2'd1: Out.Data = {DaqDataPkg::CountTag, Ctrl.TrigCount[23:16]};
					2'd2: Out.Data = Ctrl.TrigCount[15:0];
					default: Out.Data = DaqDataPkg::TailEnd;
				endcase
			end
			default: Out.Data = '0;
		endcase
	end

endmodule

// File: logic/DaqSubsystem.sv
`timescale 1ns/1ps

module DaqSubsystem (
	input  logic                Clk,
	input  logic                reset_n,
	input  logic                ModuleStart,
	input  logic                AcqStart,
	input  logic                ChipSatB,
	input  logic                EndReadout,
	input  logic [15:0]         AcquisitionTime,
	input  logic [15:0]         EndHoldTime,
	input  logic                DataTransmitDone,
	input  DaqDataPkg::ChipWord ChipIn [DaqCtrlPkg::NumChips],
	output logic                RESET_B,
	output logic                START_ACQ,
	output logic                StartReadout,
	output logic                PWR_ON_A,
	output logic                PWR_ON_D,
	output logic                PWR_ON_DAC,
	output logic                OnceEnd,
	output logic                AllDone,
	output DaqDataPkg::OutWord  Out
);

	logic ReadWindow;
	logic BurstDone;
	logic TrailerDone;
	DaqDataPkg::CtrlBus Ctrl;
	logic [DaqCtrlPkg::NumChips-1:0] Pop;
	logic [15:0] Heads [DaqCtrlPkg::NumChips];
	logic [DaqCtrlPkg::CountWidth-1:0] Counts [DaqCtrlPkg::NumChips];

	AcqSequencer i_seq (
		.Clk, .reset_n, .ModuleStart, .AcqStart, .ChipSatB, .EndReadout,
		.AcquisitionTime, .EndHoldTime, .DataTransmitDone, .BurstDone, .TrailerDone,
		.RESET_B, .START_ACQ, .StartReadout, .PWR_ON_A, .PWR_ON_D, .PWR_ON_DAC,
		.OnceEnd, .AllDone, .ReadWindow, .Ctrl
	);

	// One capture channel per ASIC
	for (genvar i = 0; i < DaqCtrlPkg::NumChips; i++) begin : gChan
		ChipChannel i_chan (
			.Clk, .reset_n, .ChipIn(ChipIn[i]), .ReadWindow,
			.Pop(Pop[i]), .Head(Heads[i]), .Count(Counts[i])
		);
	end

	EventMerger i_merge (
		.Clk, .reset_n, .Ctrl, .Heads, .Counts,
		.Pop, .Out, .BurstDone, .TrailerDone
	);

endmodule

// File: bench/DaqChecker.sv
`timescale 1ns/1ps

module DaqChecker (
	input  logic                Clk,
	input  logic                reset_n,
	input  logic                ModuleStart,
	input  logic                AcqStart,
	input  logic                EndReadout,
	input  DaqDataPkg::ChipWord ChipIn [DaqCtrlPkg::NumChips],
	input  logic                InWindow,
	input  logic                START_ACQ,
	input  logic                StartReadout,
	input  logic                PWR_ON_A,
	input  logic                PWR_ON_D,
	input  logic                PWR_ON_DAC,
	input  logic                OnceEnd,
	input  logic                AllDone,
	input  DaqDataPkg::OutWord  Out,
	output int                  ValueErrors,
	output int                  OtherErrors
);

	logic [31:0] Captured [$];                   // Channel index over data word
	logic [15:0] Expected [$];                   // Model of the output stream
	int ReadIdx = 0;
	logic [DaqCtrlPkg::TrigWidth-1:0] TrigCount;
	logic PrevStart;
	logic PrevAcq;
	logic PrevEnd;
	logic PrevAllDone = 1'b0;
	logic PrevOnceEnd = 1'b0;
	logic Busy = 1'b0;                           // From START_ACQ until OnceEnd falls

	// Markers and words in channel order, then the trigger ID
	function automatic void buildBurst();
		logic Any;
		logic First;
		Any = 1'b0;
		for (int ch = 0; ch < DaqCtrlPkg::NumChips; ch++) begin
			First = 1'b1;
			foreach (Captured[k]) begin
				if (Captured[k][31:16] == 16'(ch)) begin
					if (First)
						Expected.push_back({DaqDataPkg::MarkerTag, 8'(ch)});
					First = 1'b0;
					Any = 1'b1;
					Expected.push_back(Captured[k][15:0]);
				end
			end
		end
		if (Any) begin
			Expected.push_back({DaqDataPkg::TrigTag, TrigCount[23:16]});
			Expected.push_back(TrigCount[15:0]);
		end
		Captured.delete();
	endfunction

	//////////////////////
	// Model fed from the DUT inputs
	//////////////////////
	always @(posedge Clk) begin
		if (!reset_n) begin
			TrigCount = '0;
			PrevStart = 1'b0;
			PrevAcq = 1'b0;
			PrevEnd = 1'b0;
			Captured.delete();
		end else begin
			if (ModuleStart && !PrevStart)
				TrigCount = '0;                  // New session
			if (AcqStart && !PrevAcq)
				TrigCount = TrigCount + 1'b1;
			for (int ch = 0; ch < DaqCtrlPkg::NumChips; ch++) begin
				if (ChipIn[ch].Valid && InWindow)
					Captured.push_back({16'(ch), ChipIn[ch].Data});
			end
			if (!EndReadout && PrevEnd)
				buildBurst();
			if (!ModuleStart && PrevStart) begin
				Expected.push_back(DaqDataPkg::TailHead);
				Expected.push_back({DaqDataPkg::CountTag, TrigCount[23:16]});
				Expected.push_back(TrigCount[15:0]);
				Expected.push_back(DaqDataPkg::TailEnd);
			end
			PrevStart = ModuleStart;
			PrevAcq = AcqStart;
			PrevEnd = EndReadout;
		end
	end

	task automatic expectBit(input string Name, input logic Got, input logic Want);
		if (Got !== Want) begin
			ValueErrors++;
			$display("** Error at %0t: %s = %b, expected %b", $time, Name, Got, Want);
		end
	endtask

	//////////////////////
	// DUT outputs compared mid-cycle
	//////////////////////
	always @(negedge Clk) begin
		if (reset_n) begin
			if (Out.Valid) begin
				if (ReadIdx >= Expected.size()) begin
					OtherErrors++;
					$display("Output word %h at %0t was not expected", Out.Data, $time);
				end else begin
					if (Out.Data !== Expected[ReadIdx]) begin
						ValueErrors++;
						$display("** Error at %0t: Out.Data = %h, expected %h", $time,
							Out.Data, Expected[ReadIdx]);
					end
					ReadIdx++;
				end
			end
			if (StartReadout)
				expectBit("START_ACQ", START_ACQ, 1'b0);
			if (START_ACQ)
				Busy = 1'b1;
			else if (PrevOnceEnd && !OnceEnd)
				Busy = 1'b0;
			if (Busy) begin  // Chips stay powered for the whole acquisition
				expectBit("PWR_ON_A", PWR_ON_A, 1'b1);
				expectBit("PWR_ON_D", PWR_ON_D, 1'b1);
				expectBit("PWR_ON_DAC", PWR_ON_DAC, 1'b1);
			end
			if (AllDone && !PrevAllDone && ReadIdx != Expected.size()) begin
				OtherErrors++;
				$display("AllDone rose at %0t with %0d expected words never sent", $time,
					Expected.size() - ReadIdx);
			end
			PrevAllDone = AllDone;
			PrevOnceEnd = OnceEnd;
		end
	end

endmodule

// File: bench/DaqTb.sv
`timescale 1ns/1ps

module DaqTb;

	localparam int Sessions = 2;
	localparam int AcqPerSession = 8;
	localparam int MaxWords = 6;                 // Words per chip and acquisition
	localparam logic [15:0] AcqTime = 16'd40;
	localparam logic [15:0] HoldTime = 16'd20;

	// Generous cycle budget per acquisition and per session
	localparam int AcqCycles = int'(AcqTime) + int'(DaqCtrlPkg::TimeStartReadout)
		+ int'(HoldTime) + DaqCtrlPkg::NumChips * (MaxWords + 1) + 60;
	localparam int SessionCycles = int'(DaqCtrlPkg::TimePowerReset)
		+ int'(DaqCtrlPkg::TimeResetStart) + 40;
	localparam int CycleLimit = 16 + Sessions * (SessionCycles + AcqPerSession * AcqCycles);

	logic Clk = 1'b0;
	logic reset_n;
	logic ModuleStart;
	logic AcqStart;
	logic ChipSatB;
	logic EndReadout;
	logic DataTransmitDone;
	logic [15:0] AcquisitionTime;
	logic [15:0] EndHoldTime;
	DaqDataPkg::ChipWord ChipIn [DaqCtrlPkg::NumChips];
	logic RESET_B;
	logic START_ACQ;
	logic StartReadout;
	logic PWR_ON_A;
	logic PWR_ON_D;
	logic PWR_ON_DAC;
	logic OnceEnd;
	logic AllDone;
	DaqDataPkg::OutWord Out;

	logic InWindow;                              // Words sent now belong in the stream
	logic [31:0] Seed = 32'h3189_3dd6;
	int WordCount [DaqCtrlPkg::NumChips];
	int Cycles = 0;
	int BenchErrors = 0;
	int ValueErrors;
	int OtherErrors;

	always #4 Clk = ~Clk;

	DaqSubsystem i_dut (
		.Clk, .reset_n, .ModuleStart, .AcqStart, .ChipSatB, .EndReadout,
		.AcquisitionTime, .EndHoldTime, .DataTransmitDone, .ChipIn,
		.RESET_B, .START_ACQ, .StartReadout, .PWR_ON_A, .PWR_ON_D, .PWR_ON_DAC,
		.OnceEnd, .AllDone, .Out
	);

	DaqChecker i_check (
		.Clk, .reset_n, .ModuleStart, .AcqStart, .EndReadout, .ChipIn, .InWindow,
		.START_ACQ, .StartReadout, .PWR_ON_A, .PWR_ON_D, .PWR_ON_DAC, .OnceEnd,
		.AllDone, .Out, .ValueErrors, .OtherErrors
	);

	always @(posedge Clk) begin
		Cycles <= Cycles + 1;
		if (Cycles >= CycleLimit) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", Cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	//////////////////////
	// ASIC emulation
	//////////////////////
	function automatic logic [31:0] nextRand();
		Seed = Seed * 32'd1664525 + 32'd1013904223;  // LCG step
		return Seed;
	endfunction

	task automatic clearChips();
		for (int i = 0; i < DaqCtrlPkg::NumChips; i++)
			ChipIn[i] = '{Data: 16'h0000, Valid: 1'b0};
		InWindow = 1'b0;
	endtask

	// Mask picks the chips that send in this cycle
	task automatic sendCycle(input logic [DaqCtrlPkg::NumChips-1:0] Mask, input logic Inside);
		logic [31:0] R;
		for (int i = 0; i < DaqCtrlPkg::NumChips; i++) begin
			R = nextRand();
			ChipIn[i] = '{Data: R[31:16], Valid: Mask[i]};
		end
		InWindow = Inside;
		@(negedge Clk);
		clearChips();
	endtask

	task automatic runAcquisition(input int Index);
		logic [31:0] R;
		logic Saturate;
		int SatDelay;
		logic [DaqCtrlPkg::NumChips-1:0] Mask;
		R = nextRand();
		Saturate = R[31];
		SatDelay = 1 + int'(R[23:16] % 8'd24);   // Well inside the acquisition time
		for (int i = 0; i < DaqCtrlPkg::NumChips; i++) begin
			R = nextRand();
			WordCount[i] = (Index == 3) ? 0 : int'(R[31:16] % 16'd7);  // Index 3 is empty
		end
		AcqStart = 1'b1;
		do @(negedge Clk); while (!START_ACQ);
		AcqStart = 1'b0;
		if (Saturate) begin
			repeat (SatDelay) @(negedge Clk);
			ChipSatB = 1'b0;                     // A chip fills up
		end
		do @(negedge Clk); while (START_ACQ);
		ChipSatB = 1'b0;
		repeat (4) @(negedge Clk);
		ChipSatB = 1'b1;                         // Rise starts the readout
		sendCycle('1, 1'b0);                     // Stray words before the window
		while (!StartReadout) @(negedge Clk);
		for (int k = 0; k < MaxWords; k++) begin
			for (int i = 0; i < DaqCtrlPkg::NumChips; i++)
				Mask[i] = (k < WordCount[i]);
			sendCycle(Mask, 1'b1);
		end
		EndReadout = 1'b1;
		repeat (3) @(negedge Clk);
		EndReadout = 1'b0;
		while (!OnceEnd) @(negedge Clk);
		sendCycle('1, 1'b0);                     // Stray words after the window
		while (OnceEnd) @(negedge Clk);
	endtask

	task automatic runSession();
		ModuleStart = 1'b1;
		do @(negedge Clk); while (RESET_B);
		while (!RESET_B) @(negedge Clk);
		repeat (int'(DaqCtrlPkg::TimeResetStart) + 2) @(negedge Clk);  // RELEASE phase
		for (int a = 0; a < AcqPerSession; a++)
			runAcquisition(a);
		ModuleStart = 1'b0;
		while (!AllDone) @(negedge Clk);
		repeat (3) @(negedge Clk);
		if (!AllDone) begin
			BenchErrors++;
			$display("AllDone dropped at %0t before DataTransmitDone was given", $time);
		end
		DataTransmitDone = 1'b1;
		while (AllDone) @(negedge Clk);
		DataTransmitDone = 1'b0;
	endtask

	initial begin
		reset_n = 1'b0;
		ModuleStart = 1'b0;
		AcqStart = 1'b0;
		ChipSatB = 1'b1;
		EndReadout = 1'b0;
		DataTransmitDone = 1'b0;
		AcquisitionTime = AcqTime;
		EndHoldTime = HoldTime;
		clearChips();
		repeat (16) @(negedge Clk);
		if (!RESET_B || START_ACQ || StartReadout || OnceEnd || AllDone || Out.Valid
			|| PWR_ON_A || PWR_ON_D || PWR_ON_DAC) begin
			BenchErrors++;
			$display("Outputs are not at their reset values while reset is held");
		end
		reset_n = 1'b1;
		for (int s = 0; s < Sessions; s++)
			runSession();
		repeat (8) @(negedge Clk);
		@(posedge Clk);
		$display("Errors: %0d wrong values, %0d other failures", ValueErrors,
			OtherErrors + BenchErrors);
		if (ValueErrors + OtherErrors + BenchErrors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: project.f
common/DaqCtrlPkg.sv
common/DaqDataPkg.sv
sequencer/AcqSequencer.sv
logic/ChipChannel.sv
logic/EventMerger.sv
logic/DaqSubsystem.sv
bench/DaqChecker.sv
bench/DaqTb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module DaqTb -o daq_sim \
	> build.log 2>&1 &&
./obj_dir/daq_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
